// File: list.f
logic/hps_bus_pkg.sv
logic/hps_cmd_pkg.sv
logic/hps_frame.sv
logic/hps_regs.sv
logic/hps_download.sv
logic/hps_io.sv
verif/tb_clock.sv
verif/hps_io_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = hps_io_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/hps_io_tb.sv
`timescale 1ns/1ps

module hps_io_tb;

	localparam int n_rows = 17;
	localparam int k_none = 0, k_cfg = 1, k_joy = 2, k_status = 3, k_sdram = 4;
	localparam int k_index = 5, k_ext = 6, k_dl_on = 7, k_data = 8, k_dl_off = 9;
	localparam hps_bus_pkg::status_word_t status_a = 64'h0123_4567_89AB_CDEF;
	localparam hps_bus_pkg::status_word_t status_b = 64'hFEDC_BA98_7654_3210;
	localparam hps_bus_pkg::bus_word_t menumask_val = 16'h5A3C;
	localparam hps_bus_pkg::bus_word_t joy_raw_val = 16'h00C3;
	localparam hps_bus_pkg::file_ext_t ext_val = 32'h524F_4D20;
	localparam logic [79:0] dl_words = 80'h0F0E_A55A_BEEF_1234_C001;

	logic clk_sys, reset;
	logic io_enable, io_strobe, io_wait, status_set, ioctl_download, ioctl_wr;
	logic forced_scandoubler;
	logic ioctl_wait = 1'b0;
	logic [1:0] buttons;
	logic [7:0] ioctl_index;
	logic [31:0] rng = 32'h05225524;
	hps_bus_pkg::bus_word_t io_din, io_dout, status_menumask, joy_raw, sdram_sz;
	hps_bus_pkg::joy_word_t joystick_0, joystick_1, joystick_2;
	hps_bus_pkg::joy_word_t joystick_3, joystick_4, joystick_5;
	hps_bus_pkg::status_word_t status, status_in;
	hps_bus_pkg::file_addr_t ioctl_addr;
	hps_bus_pkg::dl_data_t ioctl_dout;
	hps_bus_pkg::file_ext_t ioctl_file_ext;

	// transfer table, one row per transfer
	hps_bus_pkg::cmd_code_t row_cmd [n_rows];
	hps_bus_pkg::bus_word_t row_arg [n_rows][6];
	hps_bus_pkg::bus_word_t row_reply [n_rows][7];
	logic [6:0] row_rchk [n_rows];
	logic [63:0] row_exp [n_rows];
	int row_len [n_rows];
	int row_kind [n_rows];
	int n_fill = 0;
	int errors = 0;
	int wr_seen = 0;
	hps_bus_pkg::bus_word_t wr_expect [$];

	assign status_menumask = menumask_val;
	assign joy_raw         = joy_raw_val;

	tb_clock clock_i (.clk_sys(clk_sys), .reset(reset));

	hps_io #(.WIDE(1'b1)) dut_i (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din),
		.io_dout(io_dout), .io_wait(io_wait),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .joystick_2(joystick_2),
		.joystick_3(joystick_3), .joystick_4(joystick_4), .joystick_5(joystick_5),
		.joy_raw(joy_raw), .buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.status(status), .status_in(status_in), .status_set(status_set),
		.status_menumask(status_menumask), .sdram_sz(sdram_sz),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_wait(ioctl_wait)
	);

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input hps_bus_pkg::bus_word_t got,
			input hps_bus_pkg::bus_word_t want);
		if (got !== want) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_joy(input string name, input hps_bus_pkg::joy_word_t got,
			input hps_bus_pkg::joy_word_t want);
		if (got !== want) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input hps_bus_pkg::status_word_t got,
			input hps_bus_pkg::status_word_t want);
		if (got !== want) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input hps_bus_pkg::file_addr_t got,
			input hps_bus_pkg::file_addr_t want);
		if (got !== want) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_ext(input string name, input hps_bus_pkg::file_ext_t got,
			input hps_bus_pkg::file_ext_t want);
		if (got !== want) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// table and host bus driver
	//////////////////////////////////////////////////

	// args hold word 1 in the low 16 bits
	task automatic add_row(input hps_bus_pkg::cmd_code_t cmd, input int len,
			input logic [95:0] args, input int kind, input logic [63:0] expect_val);
		row_cmd[n_fill]  = cmd;
		row_len[n_fill]  = len;
		for (int i = 0; i < 6; i++)
			row_arg[n_fill][i] = args[16*i +: 16];
		row_kind[n_fill] = kind;
		row_exp[n_fill]  = expect_val;
		row_rchk[n_fill] = '0;
		n_fill++;
	endtask

	task automatic set_reply(input int k, input hps_bus_pkg::bus_word_t v);
		row_reply[n_fill-1][k] = v;
		row_rchk[n_fill-1][k]  = 1'b1;
	endtask

	task automatic build_table();
		add_row(hps_cmd_pkg::cmd_cfg, 1, 96'h0013, k_cfg, 64'h13);
		add_row(hps_cmd_pkg::cmd_joy_0, 2, 96'hA000_1111, k_joy, 64'hA000_1111);
		add_row(hps_cmd_pkg::cmd_joy_1, 2, 96'hA001_2222, k_joy, 64'hA001_2222);
		add_row(hps_cmd_pkg::cmd_joy_2, 2, 96'hA002_3333, k_joy, 64'hA002_3333);
		add_row(hps_cmd_pkg::cmd_joy_3, 2, 96'hA003_4444, k_joy, 64'hA003_4444);
		add_row(hps_cmd_pkg::cmd_joy_4, 2, 96'hA004_5555, k_joy, 64'hA004_5555);
		add_row(hps_cmd_pkg::cmd_joy_5, 2, 96'hA005_6666, k_joy, 64'hA005_6666);
		add_row(hps_cmd_pkg::cmd_sdram_sz, 1, 96'h0007, k_sdram, 64'h7);
		add_row(hps_cmd_pkg::cmd_status, 4, 96'h6677_4455_2233_0011, k_status,
			64'h6677_4455_2233_0011);
		// tag above the handshake count, then the captured value low half first
		add_row(hps_cmd_pkg::cmd_status_req, 4, 96'h0, k_none, 64'h0);
		set_reply(0, {8'h00, hps_cmd_pkg::reply_tag_status, 4'd2});
		for (int i = 1; i <= 4; i++)
			set_reply(i, status_b[16*(i-1) +: 16]);
		add_row(hps_cmd_pkg::cmd_menumask, 1, 96'h0, k_none, 64'h0);
		set_reply(1, menumask_val);
		add_row(hps_cmd_pkg::cmd_joy_raw, 1, 96'h0, k_none, 64'h0);
		set_reply(1, joy_raw_val);
		add_row(hps_cmd_pkg::cmd_file_index, 1, 96'h0004, k_index, 64'h4);
		add_row(hps_cmd_pkg::cmd_file_info, 2, {ext_val[15:0], ext_val[31:16]}, k_ext, 64'h0);
		add_row(hps_cmd_pkg::cmd_file_tx, 1, 96'h00FF, k_dl_on, 64'h1);
		add_row(hps_cmd_pkg::cmd_file_data, 5, {16'h0, dl_words}, k_data, 64'd5);
		for (int i = 0; i < 5; i++)
			wr_expect.push_back(dl_words[16*i +: 16]);
		// 16-bit words step the address by 2 so the last write lands on 8
		add_row(hps_cmd_pkg::cmd_file_tx, 1, 96'h0000, k_dl_off, 64'd8);
	endtask

	task automatic send_word(input hps_bus_pkg::bus_word_t w);
		@(posedge clk_sys);
		while (io_wait)
			@(posedge clk_sys);
		io_enable <= 1'b1;
		io_din    <= w;
		io_strobe <= 1'b1;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	function automatic hps_bus_pkg::joy_word_t joy_out(input hps_bus_pkg::cmd_code_t c);
		case (c)
			hps_cmd_pkg::cmd_joy_0: return joystick_0;
			hps_cmd_pkg::cmd_joy_1: return joystick_1;
			hps_cmd_pkg::cmd_joy_2: return joystick_2;
			hps_cmd_pkg::cmd_joy_3: return joystick_3;
			hps_cmd_pkg::cmd_joy_4: return joystick_4;
			default:                return joystick_5;
		endcase
	endfunction

	task automatic check_row(input int r);
		case (row_kind[r])
			k_cfg: begin
				check_word("buttons", 16'(buttons), 16'(row_exp[r][1:0]));
				check_flag("forced_scandoubler", forced_scandoubler, row_exp[r][4]);
			end
			k_joy: check_joy($sformatf("joystick cmd %02h", row_cmd[r]),
				joy_out(row_cmd[r]), row_exp[r][31:0]);
			k_status: check_status("status", status, row_exp[r]);
			k_sdram: check_word("sdram_sz", sdram_sz, row_exp[r][15:0]);
			k_index: check_word("ioctl_index", 16'(ioctl_index), row_exp[r][15:0]);
			k_ext: check_ext("ioctl_file_ext", ioctl_file_ext, ext_val);
			k_dl_on, k_data, k_dl_off: begin
				check_word("ioctl_index", 16'(ioctl_index), 16'h0004);
				check_ext("ioctl_file_ext", ioctl_file_ext, ext_val);
				check_flag("ioctl_download", ioctl_download, row_kind[r] != k_dl_off);
				if (row_kind[r] == k_dl_off)
					check_addr("ioctl_addr", ioctl_addr, row_exp[r][26:0]);
				if (row_kind[r] == k_data && wr_seen != int'(row_exp[r])) begin
					$display("download wrote %0d words, expected %0d", wr_seen, row_exp[r]);
					errors++;
				end
			end
			default: ;
		endcase
	endtask

	task automatic send_row(input int r);
		for (int k = 0; k <= row_len[r]; k++) begin
			send_word((k == 0) ? row_cmd[r] : row_arg[r][k-1]);
			// reply to word k is read before word k+1 goes out
			if (row_rchk[r][k])
				check_word($sformatf("io_dout word %0d", k), io_dout, row_reply[r][k]);
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		// reply bus clears once the transfer is over
		check_word("io_dout after transfer", io_dout, '0);
		check_row(r);
	endtask

	task automatic pulse_status(input hps_bus_pkg::status_word_t v);
		@(posedge clk_sys);
		status_in  <= v;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		@(posedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// wait source, write monitor, watchdog
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// high on about one cycle in four
	always @(posedge clk_sys) begin
		rng        <= xorshift32(rng);
		ioctl_wait <= (rng[1:0] == 2'b00);
	end

	always @(negedge clk_sys) begin
		if (!reset)
			check_flag("io_wait", io_wait, ioctl_wait);
		if (!reset && ioctl_wr) begin
			if (wr_expect.size() == 0) begin
				$display("write pulse at %0t with no data word left to expect", $time);
				errors++;
			end else begin
				check_addr("ioctl_addr", ioctl_addr, hps_bus_pkg::file_addr_t'(2 * wr_seen));
				check_word("ioctl_dout", ioctl_dout, wr_expect.pop_front());
			end
			wr_seen++;
		end
	end

	initial begin
		repeat (n_rows * 40 + 200) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, errors %0d", n_rows * 40 + 200, errors);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		build_table();
		@(negedge reset);
		@(negedge clk_sys);
		check_joy("joystick_0", joystick_0, '0);
		check_joy("joystick_1", joystick_1, '0);
		check_joy("joystick_2", joystick_2, '0);
		check_joy("joystick_3", joystick_3, '0);
		check_joy("joystick_4", joystick_4, '0);
		check_joy("joystick_5", joystick_5, '0);
		check_status("status", status, '0);
		check_word("buttons", 16'(buttons), '0);
		check_word("sdram_sz", sdram_sz, '0);
		check_flag("ioctl_download", ioctl_download, 1'b0);
		// two captures, the request must report the second
		pulse_status(status_a);
		pulse_status(status_b);
		for (int r = 0; r < n_rows; r++)
			send_row(r);
		if (wr_expect.size() != 0) begin
			$display("%0d download words never reached the write port", wr_expect.size());
			errors++;
		end
		$display("errors %0d, write pulses %0d", errors, wr_seen);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

// File: logic/hps_io.sv
`timescale 1ns/1ps

module hps_io #(
	parameter bit WIDE = 1'b0
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	// host command bus
	input  logic                      io_enable,
	input  logic                      io_strobe,
	input  hps_bus_pkg::bus_word_t    io_din,
	output hps_bus_pkg::bus_word_t    io_dout,
	output logic                      io_wait,

	// control registers
	output hps_bus_pkg::joy_word_t    joystick_0,
	output hps_bus_pkg::joy_word_t    joystick_1,
	output hps_bus_pkg::joy_word_t    joystick_2,
	output hps_bus_pkg::joy_word_t    joystick_3,
	output hps_bus_pkg::joy_word_t    joystick_4,
	output hps_bus_pkg::joy_word_t    joystick_5,
	input  hps_bus_pkg::bus_word_t    joy_raw,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output hps_bus_pkg::status_word_t status,
	input  hps_bus_pkg::status_word_t status_in,
	input  logic                      status_set,
	input  hps_bus_pkg::bus_word_t    status_menumask,
	output hps_bus_pkg::bus_word_t    sdram_sz,

	// file download
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic                      ioctl_wr,
	output hps_bus_pkg::file_addr_t   ioctl_addr,
	output hps_bus_pkg::dl_data_t     ioctl_dout,
	output hps_bus_pkg::file_ext_t    ioctl_file_ext,
	input  logic                      ioctl_wait
);

	logic                   frame_valid;
	logic                   frame_ready;
	hps_bus_pkg::cmd_code_t frame_cmd;
	hps_bus_pkg::word_idx_t frame_idx;
	hps_bus_pkg::bus_word_t frame_data;
	logic                   frame_end;
	logic                   regs_ready;
	logic                   dl_ready;

	// the host holds off while the core is busy with a write
	assign io_wait = ioctl_wait;

	// both stages see every word
	assign frame_ready = regs_ready & dl_ready;

	hps_frame frame_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.frame_valid (frame_valid),
		.frame_cmd   (frame_cmd),
		.frame_idx   (frame_idx),
		.frame_data  (frame_data),
		.frame_end   (frame_end),
		.frame_ready (frame_ready)
	);

	hps_regs regs_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.frame_valid        (frame_valid),
		.frame_cmd          (frame_cmd),
		.frame_idx          (frame_idx),
		.frame_data         (frame_data),
		.frame_end          (frame_end),
		.regs_ready         (regs_ready),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.joy_raw            (joy_raw),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.sdram_sz           (sdram_sz),
		.io_dout            (io_dout)
	);

	hps_download #(
		.WIDE (WIDE)
	) download_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame_valid    (frame_valid),
		.frame_cmd      (frame_cmd),
		.frame_idx      (frame_idx),
		.frame_data     (frame_data),
		.dl_ready       (dl_ready),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

// File: logic/hps_download.sv
`timescale 1ns/1ps

module hps_download #(
	parameter bit WIDE = 1'b0
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   frame_valid,
	input  hps_bus_pkg::cmd_code_t frame_cmd,
	input  hps_bus_pkg::word_idx_t frame_idx,
	input  hps_bus_pkg::bus_word_t frame_data,
	output logic                   dl_ready,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic                   ioctl_wr,
	output hps_bus_pkg::file_addr_t ioctl_addr,
	output hps_bus_pkg::dl_data_t  ioctl_dout,
	output hps_bus_pkg::file_ext_t ioctl_file_ext
);

	// bytes per data word and the part of the bus word they use
	localparam int dl_bits = WIDE ? 16 : 8;
	localparam hps_bus_pkg::file_addr_t addr_step = hps_bus_pkg::file_addr_t'(WIDE ? 2 : 1);
	localparam hps_bus_pkg::dl_data_t data_mask = hps_bus_pkg::dl_data_t'((1 << dl_bits) - 1);

	typedef enum logic {
		dl_idle,
		dl_active
	} dl_state_t;

	dl_state_t               dl_state;
	hps_bus_pkg::file_addr_t addr;
	logic                    word_hit;

	// every write finishes in a single cycle
	assign dl_ready = 1'b1;

	assign ioctl_download = (dl_state == dl_active);

	// argument words only, word 0 is the command itself
	assign word_hit = frame_valid & (frame_idx != '0);

	//////////////////////////////////////////////////
	// file transfer control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_state       <= dl_idle;
			addr           <= '0;
			ioctl_addr     <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (word_hit) begin
				case (frame_cmd)
					hps_cmd_pkg::cmd_file_info:
						// upper half of the extension comes first
						case (frame_idx)
							1:       ioctl_file_ext[31:16] <= frame_data;
							2:       ioctl_file_ext[15:0]  <= frame_data;
							default: ;
						endcase
					hps_cmd_pkg::cmd_file_index:
						if (frame_idx == 1)
							ioctl_index <= frame_data[7:0];
					hps_cmd_pkg::cmd_file_tx:
						if (frame_idx == 1) begin
							if (frame_data[7:0] != 8'h00) begin
								addr     <= '0;
								dl_state <= dl_active;
							end else begin
								// ioctl_addr keeps the address of the last write
								dl_state <= dl_idle;
							end
						end
					hps_cmd_pkg::cmd_file_data: begin
						ioctl_addr <= addr;
						ioctl_wr   <= 1'b1;
						addr       <= addr + addr_step;
					end
					default: ;
				endcase
			end
		end
	end

	// write data travels with the strobe
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			ioctl_dout <= '0;
		else if (word_hit && frame_cmd == hps_cmd_pkg::cmd_file_data)
			ioctl_dout <= frame_data & data_mask;
	end

endmodule

// File: logic/hps_regs.sv
`timescale 1ns/1ps

module hps_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      frame_valid,
	input  hps_bus_pkg::cmd_code_t    frame_cmd,
	input  hps_bus_pkg::word_idx_t    frame_idx,
	input  hps_bus_pkg::bus_word_t    frame_data,
	input  logic                      frame_end,
	output logic                      regs_ready,
	input  hps_bus_pkg::status_word_t status_in,
	input  logic                      status_set,
	input  hps_bus_pkg::bus_word_t    status_menumask,
	input  hps_bus_pkg::bus_word_t    joy_raw,
	output hps_bus_pkg::joy_word_t    joystick_0,
	output hps_bus_pkg::joy_word_t    joystick_1,
	output hps_bus_pkg::joy_word_t    joystick_2,
	output hps_bus_pkg::joy_word_t    joystick_3,
	output hps_bus_pkg::joy_word_t    joystick_4,
	output hps_bus_pkg::joy_word_t    joystick_5,
	output hps_bus_pkg::status_word_t status,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output hps_bus_pkg::bus_word_t    sdram_sz,
	output hps_bus_pkg::bus_word_t    io_dout
);

	logic [7:0]                cfg;
	hps_bus_pkg::joy_word_t    joy_q [6];
	logic [2:0]                joy_sel;
	logic                      joy_hit;
	logic                      set_q;
	logic [3:0]                set_cnt;
	hps_bus_pkg::status_word_t status_req;

	// register updates take one cycle and never stall
	assign regs_ready = 1'b1;

	// the other cfg bits belong to functions this core leaves out
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign joystick_0 = joy_q[0];
	assign joystick_1 = joy_q[1];
	assign joystick_2 = joy_q[2];
	assign joystick_3 = joy_q[3];
	assign joystick_4 = joy_q[4];
	assign joystick_5 = joy_q[5];

	// joystick number from command code
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (frame_cmd)
			hps_cmd_pkg::cmd_joy_0: joy_sel = 3'd0;
			hps_cmd_pkg::cmd_joy_1: joy_sel = 3'd1;
			hps_cmd_pkg::cmd_joy_2: joy_sel = 3'd2;
			hps_cmd_pkg::cmd_joy_3: joy_sel = 3'd3;
			hps_cmd_pkg::cmd_joy_4: joy_sel = 3'd4;
			hps_cmd_pkg::cmd_joy_5: joy_sel = 3'd5;
			default:                joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// control registers written by the host
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg      <= '0;
			status   <= '0;
			sdram_sz <= '0;
			for (int i = 0; i < 6; i++)
				joy_q[i] <= '0;
		end else if (frame_valid && frame_idx != '0) begin
			if (joy_hit) begin
				// low half first
				if (frame_idx == 1)
					joy_q[joy_sel][15:0] <= frame_data;
				if (frame_idx == 2)
					joy_q[joy_sel][31:16] <= frame_data;
			end
			case (frame_cmd)
				hps_cmd_pkg::cmd_cfg:
					if (frame_idx == 1)
						cfg <= frame_data[7:0];
				hps_cmd_pkg::cmd_status:
					case (frame_idx)
						1:       status[15:0]  <= frame_data;
						2:       status[31:16] <= frame_data;
						3:       status[47:32] <= frame_data;
						4:       status[63:48] <= frame_data;
						default: ;
					endcase
				hps_cmd_pkg::cmd_sdram_sz:
					if (frame_idx == 1)
						sdram_sz <= frame_data;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// core status request
	//////////////////////////////////////////////////

	// rising edge of status_set captures a new value for the host
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			set_q      <= 1'b0;
			set_cnt    <= '0;
			status_req <= '0;
		end else begin
			set_q <= status_set;
			if (status_set && !set_q) begin
				set_cnt    <= set_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////////////////////////
	// read replies
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (frame_end) begin
			io_dout <= '0;
		end else if (frame_valid) begin
			io_dout <= '0;
			if (frame_idx == '0) begin
				// handshake word lets the host see a new request
				if (frame_cmd == hps_cmd_pkg::cmd_status_req)
					io_dout <= {8'h00, hps_cmd_pkg::reply_tag_status, set_cnt};
			end else begin
				case (frame_cmd)
					hps_cmd_pkg::cmd_status_req:
						case (frame_idx)
							1:       io_dout <= status_req[15:0];
							2:       io_dout <= status_req[31:16];
							3:       io_dout <= status_req[47:32];
							4:       io_dout <= status_req[63:48];
							default: ;
						endcase
					hps_cmd_pkg::cmd_menumask:
						if (frame_idx == 1)
							io_dout <= status_menumask;
					hps_cmd_pkg::cmd_joy_raw:
						io_dout <= joy_raw;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: logic/hps_frame.sv
`timescale 1ns/1ps

module hps_frame (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  hps_bus_pkg::bus_word_t io_din,
	output logic                   frame_valid,
	output hps_bus_pkg::cmd_code_t frame_cmd,
	output hps_bus_pkg::word_idx_t frame_idx,
	output hps_bus_pkg::bus_word_t frame_data,
	output logic                   frame_end,
	input  logic                   frame_ready
);

	// position of the next word and command of the open transfer
	hps_bus_pkg::word_idx_t word_cnt;
	hps_bus_pkg::cmd_code_t cmd_q;
	logic                   enable_q;
	logic                   stall;
	logic                   take_word;

	// a word still waiting for the consumers blocks the register
	assign stall     = frame_valid & ~frame_ready;
	assign take_word = io_enable & io_strobe & ~stall;

	//////////////////////////////////////////////////
	// transfer context
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			word_cnt  <= '0;
			cmd_q     <= '0;
			enable_q  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			enable_q  <= io_enable;
			frame_end <= enable_q & ~io_enable;
			if (!io_enable) begin
				word_cnt <= '0;
				cmd_q    <= '0;
			end else if (take_word) begin
				// first word of a transfer is the command
				if (word_cnt == '0)
					cmd_q <= io_din;
				// counter sticks at its top value
				if (~&word_cnt)
					word_cnt <= word_cnt + hps_bus_pkg::word_idx_t'(1);
			end
		end
	end

	//////////////////////////////////////////////////
	// output word register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			frame_valid <= 1'b0;
		else if (take_word)
			frame_valid <= 1'b1;
		else if (frame_ready)
			frame_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take_word) begin
			frame_idx  <= word_cnt;
			frame_data <= io_din;
			frame_cmd  <= (word_cnt == '0) ? io_din : cmd_q;
		end
	end

endmodule

// File: logic/hps_cmd_pkg.sv
package hps_cmd_pkg;

	//////////////////////////////////////////////////
	// control register commands
	//////////////////////////////////////////////////

	localparam hps_bus_pkg::cmd_code_t cmd_cfg        = 16'h0001;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_0      = 16'h0002;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_1      = 16'h0003;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_2      = 16'h0010;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_3      = 16'h0011;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_4      = 16'h0012;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_5      = 16'h0013;
	localparam hps_bus_pkg::cmd_code_t cmd_status     = 16'h001E;
	localparam hps_bus_pkg::cmd_code_t cmd_status_req = 16'h0029;
	localparam hps_bus_pkg::cmd_code_t cmd_menumask   = 16'h002E;
	localparam hps_bus_pkg::cmd_code_t cmd_joy_raw    = 16'h000F;
	localparam hps_bus_pkg::cmd_code_t cmd_sdram_sz   = 16'h0031;

	// file transfer into the core
	localparam hps_bus_pkg::cmd_code_t cmd_file_tx    = 16'h0053;
	localparam hps_bus_pkg::cmd_code_t cmd_file_data  = 16'h0054;
	localparam hps_bus_pkg::cmd_code_t cmd_file_index = 16'h0055;
	localparam hps_bus_pkg::cmd_code_t cmd_file_info  = 16'h0056;

	// upper nibble of the status request reply, counter sits below it
	localparam logic [3:0] reply_tag_status = 4'hA;

endpackage

// File: logic/hps_bus_pkg.sv
package hps_bus_pkg;

	//////////////////////////////////////////////////
	// field widths of the host bus
	//////////////////////////////////////////////////

	localparam int bus_word_w    = 16;
	localparam int word_idx_w    = 10;
	localparam int cmd_code_w    = 16;
	localparam int joy_word_w    = 32;
	localparam int status_word_w = 64;
	localparam int file_addr_w   = 27;
	localparam int file_ext_w    = 32;

	// sized for 16-bit downloads, 8-bit mode keeps the top byte at zero
	localparam int dl_data_w     = 16;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [bus_word_w-1:0]    bus_word_t;
	typedef logic [word_idx_w-1:0]    word_idx_t;
	typedef logic [cmd_code_w-1:0]    cmd_code_t;
	typedef logic [joy_word_w-1:0]    joy_word_t;
	typedef logic [status_word_w-1:0] status_word_t;
	typedef logic [file_addr_w-1:0]   file_addr_t;
	typedef logic [file_ext_w-1:0]    file_ext_t;
	typedef logic [dl_data_w-1:0]     dl_data_t;

endpackage
